// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  mem_size_t;
  typedef logic [1:0]  wb_src_t;

  // ALU codes follow {inst[30], func3} so decode can pass them through
  localparam alu_op_t ALU_ADD   = 4'b0000;
  localparam alu_op_t ALU_SUB   = 4'b1000;
  localparam alu_op_t ALU_SLL   = 4'b0001;
  localparam alu_op_t ALU_SLT   = 4'b0010;
  localparam alu_op_t ALU_SLTU  = 4'b0011;
  localparam alu_op_t ALU_XOR   = 4'b0100;
  localparam alu_op_t ALU_SRL   = 4'b0101;
  localparam alu_op_t ALU_SRA   = 4'b1101;
  localparam alu_op_t ALU_OR    = 4'b0110;
  localparam alu_op_t ALU_AND   = 4'b0111;
  localparam alu_op_t ALU_PASSB = 4'b1111;

  localparam mem_size_t SZ_BYTE = 2'd0; // Same as func3[1:0]
  localparam mem_size_t SZ_HALF = 2'd1;
  localparam mem_size_t SZ_WORD = 2'd2;

  localparam wb_src_t WB_ALU = 2'd0;
  localparam wb_src_t WB_MEM = 2'd1;
  localparam wb_src_t WB_PC4 = 2'd2;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [1:0] {
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } core_state_e;

endpackage

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  input  logic [2:0]      br_cond,
  output rv_pkg::word_t   result,
  output logic            br_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;
      ALU_SLL:   result = a << shamt;
      ALU_SLT:   result = {31'b0, lt_s};
      ALU_SLTU:  result = {31'b0, lt_u};
      ALU_XOR:   result = a ^ b;
      ALU_SRL:   result = a >> shamt;
      ALU_SRA:   result = $signed(a) >>> shamt;
      ALU_OR:    result = a | b;
      ALU_AND:   result = a & b;
      ALU_PASSB: result = b; // LUI
      default:   result = a + b;
    endcase
  end

  always_comb begin
    case (br_cond)
      3'b000:  br_taken = (a == b);
      3'b001:  br_taken = (a != b);
      3'b100:  br_taken = lt_s;
      3'b101:  br_taken = !lt_s;
      3'b110:  br_taken = lt_u;
      3'b111:  br_taken = !lt_u;
      default: br_taken = 1'b0;
    endcase
  end

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t     inst,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              src_a_pc,
  output logic              src_b_imm,
  output logic              rd_wen,
  output rv_pkg::wb_src_t   wb_src,
  output logic              is_load,
  output logic              is_store,
  output logic              mem_unsigned,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_ebreak,
  output logic              is_illegal,
  output rv_pkg::mem_size_t mem_size,
  output logic [2:0]        br_cond
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] func3;
  logic [6:0] func7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       wen_raw;

  assign opcode = inst[6:0];
  assign func3  = inst[14:12];
  assign func7  = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign mem_size     = inst[13:12];
  assign mem_unsigned = func3[2];
  assign br_cond      = func3;
  assign rd_wen       = wen_raw && (rd != 5'd0); // x0 never written

  always_comb begin
    imm        = imm_i;
    alu_op     = ALU_ADD;
    src_a_pc   = 1'b0;
    src_b_imm  = 1'b0;
    wen_raw    = 1'b0;
    wb_src     = WB_ALU;
    is_load    = 1'b0;
    is_store   = 1'b0;
    is_branch  = 1'b0;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm       = imm_u;
        alu_op    = ALU_PASSB;
        src_b_imm = 1'b1;
        wen_raw   = 1'b1;
      end
      OP_AUIPC: begin
        imm       = imm_u;
        src_a_pc  = 1'b1;
        src_b_imm = 1'b1;
        wen_raw   = 1'b1;
      end
      OP_JAL: begin
        imm     = imm_j;
        is_jal  = 1'b1;
        wen_raw = 1'b1;
        wb_src  = WB_PC4;
      end
      OP_JALR: begin
        src_b_imm  = 1'b1;   // ALU forms rs1 + imm
        is_jalr    = (func3 == 3'b000);
        wen_raw    = (func3 == 3'b000);
        wb_src     = WB_PC4;
        is_illegal = (func3 != 3'b000);
      end
      OP_BRANCH: begin
        imm        = imm_b;
        is_branch  = (func3[2:1] != 2'b01);
        is_illegal = (func3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        src_b_imm  = 1'b1;
        wb_src     = WB_MEM;
        is_illegal = (func3 == 3'b011) || (func3[2:1] == 2'b11);
        is_load    = !is_illegal;
        wen_raw    = !is_illegal;
      end
      OP_STORE: begin
        imm        = imm_s;
        src_b_imm  = 1'b1;
        is_illegal = (func3[2] || func3 == 3'b011);
        is_store   = !is_illegal;
      end
      OP_IMM: begin
        src_b_imm  = 1'b1;
        wen_raw    = 1'b1;
        alu_op     = {(func3 == 3'b101) && inst[30], func3};
        if (func3 == 3'b001)
          is_illegal = (func7 != 7'b0000000);
        else if (func3 == 3'b101)
          is_illegal = (func7 != 7'b0000000) && (func7 != 7'b0100000);
      end
      OP_REG: begin
        wen_raw    = 1'b1;
        alu_op     = {inst[30], func3};
        is_illegal = !((func7 == 7'b0000000) ||
                       (func7 == 7'b0100000 && (func3 == 3'b000 || func3 == 3'b101)));
      end
      OP_SYSTEM: begin
        is_ebreak  = (inst == 32'h0010_0073);
        is_illegal = (inst != 32'h0010_0073); // No ECALL or CSR
      end
      default: is_illegal = 1'b1;
    endcase
  end

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  logic              wen
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1]; // x0 reads zero
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              we,
  input  logic              unsigned_ld,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     wdata,
  input  rv_pkg::mem_size_t size,
  output logic              done,
  output rv_pkg::word_t     rdata,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [29:0]       wb_adr,
  output logic [3:0]        wb_sel,
  output rv_pkg::word_t     wb_wdata,
  input  rv_pkg::word_t     wb_rdata,
  input  logic              wb_ack
);
  import rv_pkg::*;

  logic      busy;
  logic      we_q;
  logic      uns_q;
  mem_size_t size_q;
  logic [1:0] off;
  logic [1:0] off_q;
  word_t     lane_data;
  logic [3:0] sel;
  word_t     shifted;

  // Lane offset, low bits assumed aligned to the size
  assign off = (size == SZ_BYTE) ? addr[1:0] :
               (size == SZ_HALF) ? {addr[1], 1'b0} : 2'b00;
  assign sel = (size == SZ_BYTE) ? (4'b0001 << off) :
               (size == SZ_HALF) ? (4'b0011 << off) : 4'b1111;
  assign lane_data = (size == SZ_BYTE) ? {4{wdata[7:0]}} :
                     (size == SZ_HALF) ? {2{wdata[15:0]}} : wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (start && !busy) begin
      busy <= 1'b1;
    end else if (busy && wb_ack) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      we_q     <= we;
      uns_q    <= unsigned_ld;
      size_q   <= size;
      off_q    <= off;
      wb_adr   <= addr[31:2];
      wb_sel   <= sel;
      wb_wdata <= lane_data;
    end
  end

  assign wb_cyc = busy;
  assign wb_stb = busy;
  assign wb_we  = busy && we_q;
  assign done   = busy && wb_ack;

  assign shifted = wb_rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SZ_BYTE: rdata = {{24{!uns_q && shifted[7]}}, shifted[7:0]};
      SZ_HALF: rdata = {{16{!uns_q && shifted[15]}}, shifted[15:0]};
      default: rdata = shifted;
    endcase
  end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output logic [29:0]   wb_adr,
  output logic [3:0]    wb_sel,
  output rv_pkg::word_t wb_wdata,
  input  rv_pkg::word_t wb_rdata,
  input  logic          wb_ack,
  output logic          halted,
  output logic          illegal
);
  import rv_pkg::*;

  core_state_e state;
  word_t       pc, pc_plus4, pc_target, next_pc;
  reg_addr_t   rs1, rs2, rd;
  word_t       imm, rs1_data, rs2_data, alu_a, alu_b, alu_result, rf_wdata, lsu_rdata;
  alu_op_t     alu_op;
  wb_src_t     wb_src;
  mem_size_t   mem_size;
  logic [2:0]  br_cond;
  logic        src_a_pc, src_b_imm, rd_wen, is_load, is_store, mem_unsigned;
  logic        is_branch, is_jal, is_jalr, is_ebreak, is_illegal, br_taken;
  logic        mem_start, lsu_done, exec_done, complete;
  logic        illegal_q;

  rv_decode decode_i (
    .inst(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .src_a_pc(src_a_pc), .src_b_imm(src_b_imm), .rd_wen(rd_wen), .wb_src(wb_src),
    .is_load(is_load), .is_store(is_store), .mem_unsigned(mem_unsigned),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_ebreak(is_ebreak),
    .is_illegal(is_illegal), .mem_size(mem_size), .br_cond(br_cond)
  );

  rv_regfile regfile_i (
    .clk(clk), .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
    .waddr(rd), .wdata(rf_wdata), .wen(rd_wen && complete)
  );

  assign alu_a = src_a_pc ? pc : rs1_data;
  assign alu_b = src_b_imm ? imm : rs2_data;

  rv_alu alu_i (
    .a(alu_a), .b(alu_b), .op(alu_op), .br_cond(br_cond),
    .result(alu_result), .br_taken(br_taken)
  );

  assign mem_start = (state == ST_EXEC) && (is_load || is_store);

  rv_lsu lsu_i (
    .clk(clk), .rst(rst), .start(mem_start), .we(is_store), .unsigned_ld(mem_unsigned),
    .addr(alu_result), .wdata(rs2_data), .size(mem_size), .done(lsu_done),
    .rdata(lsu_rdata), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_wdata(wb_wdata),
    .wb_rdata(wb_rdata), .wb_ack(wb_ack)
  );

  assign exec_done = (state == ST_EXEC) && !(is_load || is_store || is_ebreak || is_illegal);
  assign complete  = exec_done || (state == ST_MEM && lsu_done);

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign next_pc   = is_jalr ? {alu_result[31:1], 1'b0} :
                     (is_jal || (is_branch && br_taken)) ? pc_target : pc_plus4;

  always_comb begin
    case (wb_src)
      WB_MEM:  rf_wdata = lsu_rdata;
      WB_PC4:  rf_wdata = pc_plus4;
      default: rf_wdata = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_EXEC;
      pc        <= RESET_PC;
      illegal_q <= 1'b0;
    end else begin
      if (complete) pc <= next_pc;
      case (state)
        ST_EXEC: begin
          if (is_illegal) begin
            state     <= ST_HALT;
            illegal_q <= 1'b1;
          end else if (is_ebreak) begin
            state <= ST_HALT;
          end else if (is_load || is_store) begin
            state <= ST_MEM;
          end
        end
        ST_MEM:  if (lsu_done) state <= ST_EXEC; // PC held until ack
        default: state <= ST_HALT;
      endcase
    end
  end

  assign imem_addr = pc;
  assign halted    = (state == ST_HALT);
  assign illegal   = illegal_q;

endmodule

// ==== hdl/rv_top.sv ====
`timescale 1ns/1ps

module rv_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output logic [29:0]   wb_adr,
  output logic [3:0]    wb_sel,
  output rv_pkg::word_t wb_wdata,
  input  rv_pkg::word_t wb_rdata,
  input  logic          wb_ack,
  output logic          halted,
  output logic          illegal
);

  rv_core #(
    .RESET_PC(RESET_PC)
  ) core_i (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_sel(wb_sel), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
    .halted(halted), .illegal(illegal)
  );

endmodule

// ==== tb/rv_tb.sv ====
`timescale 1ns/1ps

module rv_tb #(
  parameter string TRACE_FILE = "tb/rv_trace.txt",
  parameter int    SEED       = 34
);
  localparam logic [31:0] PROG_BASE = 32'h8000_0000;
  localparam int          LIMIT     = 200; // Cycles per wait

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr, imem_data, wb_wdata, wb_rdata;
  logic        wb_cyc, wb_stb, wb_we, wb_ack, halted, illegal;
  logic [29:0] wb_adr;
  logic [3:0]  wb_sel;

  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [29:0]];
  logic [29:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  logic [3:0]  exp_sel [$];
  int          writes_seen;
  int          halt_exp;
  int          fd;

  // Slave snapshot of the open transfer
  bit          in_xfer;
  int          wait_left;
  logic [29:0] snap_adr;
  logic [3:0]  snap_sel;
  logic [31:0] snap_dat, snap_pc;
  logic        snap_we;

  rv_top #(
    .RESET_PC(PROG_BASE)
  ) rv_top_i (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_sel(wb_sel), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
    .halted(halted), .illegal(illegal)
  );

  always #2 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED %s got %h expected %h", name, got, expected);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic abort(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[8*i +: 8] = nw[8*i +: 8];
    end
    return res;
  endfunction

  always @(negedge clk) begin
    imem_data <= imem.exists(imem_addr) ? imem[imem_addr] : 32'h0;
  end

  // Wishbone slave with random wait states
  always @(negedge clk) begin
    if (rst) begin
      wb_ack  <= 1'b0;
      in_xfer = 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_xfer) begin
        in_xfer   = 1'b1;
        wait_left = $urandom % 4;
        snap_adr  = wb_adr;
        snap_sel  = wb_sel;
        snap_dat  = wb_wdata;
        snap_we   = wb_we;
        snap_pc   = imem_addr;
      end
      check("wb_adr", {2'b0, wb_adr}, {2'b0, snap_adr});
      check("wb_sel", {28'b0, wb_sel}, {28'b0, snap_sel});
      check("wb_wdata", wb_wdata, snap_dat);
      check("wb_we", {31'b0, wb_we}, {31'b0, snap_we});
      check("imem_addr", imem_addr, snap_pc);
      if (wait_left == 0) begin
        in_xfer = 1'b0;
        wb_ack   <= 1'b1;
        wb_rdata <= dmem.exists(wb_adr) ? dmem[wb_adr] : 32'h0;
        if (wb_we) begin
          if (exp_adr.size() == 0) abort("bus write seen with no write left in the trace");
          check("wb_adr", {2'b0, wb_adr}, {2'b0, exp_adr.pop_front()});
          check("wb_wdata", wb_wdata, exp_dat.pop_front());
          check("wb_sel", {28'b0, wb_sel}, {28'b0, exp_sel.pop_front()});
          dmem[wb_adr] = merge_lanes(dmem.exists(wb_adr) ? dmem[wb_adr] : 32'h0,
                                     wb_wdata, wb_sel);
          writes_seen++;
        end
      end else begin
        wait_left--;
      end
    end
  end

  // Reads records up to the next H record
  task automatic read_section(output bit got);
    logic [7:0]  kind;
    logic [31:0] a, d, s;
    bit          fin;
    int          n;
    string       line_buf;
    got = 1'b0;
    fin = 1'b0;
    imem.delete();
    dmem.delete();
    while (!fin && $fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": void'($fgets(line_buf, fd));
        "I": begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) abort("malformed I record in the trace");
          imem[a] = d;
        end
        "D": begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) abort("malformed D record in the trace");
          dmem[a[29:0]] = d;
        end
        "W": begin
          n = $fscanf(fd, "%h %h %h", a, d, s);
          if (n != 3) abort("malformed W record in the trace");
          exp_adr.push_back(a[29:0]);
          exp_dat.push_back(d);
          exp_sel.push_back(s[3:0]);
        end
        "P": begin
          n = $fscanf(fd, "%h", a);
          if (n != 1) abort("malformed P record in the trace");
          check("program base", a, PROG_BASE);
        end
        "H": begin
          n = $fscanf(fd, "%d", halt_exp);
          if (n != 1) abort("malformed H record in the trace");
          fin = 1'b1;
        end
        default: abort("unknown record kind in trace");
      endcase
      got = 1'b1;
    end
  endtask

  task automatic run_section();
    int n;
    int target;
    rst <= 1'b1;
    writes_seen = 0;
    repeat (10) @(negedge clk);
    check("imem_addr", imem_addr, PROG_BASE);
    check("wb_cyc", {31'b0, wb_cyc}, 32'h0);
    check("wb_stb", {31'b0, wb_stb}, 32'h0);
    check("wb_we", {31'b0, wb_we}, 32'h0);
    check("halted", {31'b0, halted}, 32'h0);
    check("illegal", {31'b0, illegal}, 32'h0);
    rst <= 1'b0;
    target = exp_adr.size();
    for (int w = 1; w <= target; w++) begin
      n = 0;
      while (writes_seen < w && n < LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (writes_seen < w) abort($sformatf("timeout waiting for bus write %0d", w));
    end
    n = 0;
    while (!halted && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!halted) abort("timeout waiting for the core to halt");
    check("illegal", {31'b0, illegal}, halt_exp);
    repeat (8) begin
      @(negedge clk);
      check("wb_cyc after halt", {31'b0, wb_cyc}, 32'h0);
      check("wb_stb after halt", {31'b0, wb_stb}, 32'h0);
      check("halted", {31'b0, halted}, 32'h1);
    end
  endtask

  initial begin
    bit got;
    int sections;
    clk       = 1'b0;
    rst       = 1'b1;
    imem_data = 32'h0;
    wb_rdata  = 32'h0;
    wb_ack    = 1'b0;
    sections  = 0;
    void'($urandom(SEED));
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) abort("could not open the trace file");
    read_section(got);
    while (got) begin
      run_section();
      sections++;
      read_section(got);
    end
    if (sections == 0) begin
      abort("the trace holds no section");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
hdl/rv_top.sv
tb/rv_tb.sv

// ==== Makefile ====
# Verilator build for the RV32I core testbench
VERILATOR ?= verilator
TOP       ?= rv_tb
TRACE     ?= tb/rv_trace.txt
SEED      ?= 34
BUILD     ?= obj_dir
FLIST     ?= sim.f

VFLAGS ?= --binary --timing --top-module $(TOP) -Mdir $(BUILD)
VPARAMS = -GTRACE_FILE='"$(TRACE)"' -GSEED=$(SEED)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(VPARAMS) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== tb/rv_trace.txt ====
# P base | I byte_addr word | D word_addr word | W word_addr data sel | H 0=ebreak 1=illegal
# Section 1: ALU ops, byte/half/word access, branches, JAL, EBREAK
P 80000000
D 20000402 11223344
D 20000405 80017fff
I 80000000 800010b7
I 80000004 ffb00113
I 80000008 00300193
I 8000000c 00310233
I 80000010 0040a023
I 80000014 403152b3
I 80000018 0050a223
I 8000001c 002084a3
I 80000020 00908303
I 80000024 0090c383
I 80000028 0060a623
I 8000002c 0070a823
I 80000030 01609403
I 80000034 0160d483
I 80000038 00209b23
I 8000003c 0080ac23
I 80000040 0090ae23
I 80000044 00314463
I 80000048 0040a023
I 8000004c 00316463
I 80000050 0230a023
I 80000054 0080056f
I 80000058 0040a023
I 8000005c 02a0a223
I 80000060 00100073
W 20000400 fffffffe f
W 20000401 ffffffff f
W 20000402 fbfbfbfb 2
W 20000403 fffffffb f
W 20000404 000000fb f
W 20000405 fffbfffb c
W 20000406 ffff8001 f
W 20000407 00008001 f
W 20000408 00000003 f
W 20000409 80000058 f
H 0
# Section 2: illegal word at the base
P 80000000
I 80000000 ffffffff
H 1
